// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_store_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/lsu_pkg.sv
design/store_buffer.sv
design/store_fifo.sv
design/wb_store_master.sv
design/store_unit_top.sv
test/wb_mem_model.sv
test/tb_store_unit.sv

// File: design/lsu_pkg.sv
package lsu_pkg;

    // bus widths shared by the store path
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = 4;

    // one 70-bit store buffer slot
    // valid marks an occupied slot and commit a retired store
    typedef struct packed {
        logic [ADDR_W-1:0] target_addr;
        logic [DATA_W-1:0] write_data;
        logic [STRB_W-1:0] wstrb;
        logic              valid;
        logic              commit;
    } sb_entry_t;

    // stores retired per cycle range from 0 to 2
    typedef logic [1:0] commit_cnt_t;

endpackage

// File: design/store_buffer.sv
module store_buffer #(
    parameter int unsigned SB_SIZE = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush_i,
    input  lsu_pkg::commit_cnt_t            commit_cnt_i,
    input  logic                            store_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0]      store_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]      store_data_i,
    input  logic [lsu_pkg::STRB_W-1:0]      store_strb_i,
    output logic                            store_ready_o,
    output logic                            out_valid_o,
    output lsu_pkg::sb_entry_t              out_entry_o,
    input  logic                            out_ready_i
);

    localparam int unsigned PTR_W = $clog2(SB_SIZE);
    localparam int unsigned CNT_W = PTR_W + 1;

    lsu_pkg::sb_entry_t entries [SB_SIZE];
    lsu_pkg::sb_entry_t new_entry;

    // head is the next free slot, cmt the oldest uncommitted, tail the oldest entry
    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   cmt_q;
    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W-1:0]   cmt_nxt;
    // occupied slots and committed slots
    logic [CNT_W-1:0]   cnt_q;
    logic [CNT_W-1:0]   ccnt_q;
    logic [CNT_W-1:0]   ucnt;
    logic [SB_SIZE-1:0] mark;
    logic               push;
    logic               pop;

    assign store_ready_o = cnt_q < CNT_W'(SB_SIZE);
    assign push          = store_valid_i & store_ready_o;
    assign pop           = out_valid_o & out_ready_i;
    assign ucnt          = cnt_q - ccnt_q;
    assign cmt_nxt       = cmt_q + PTR_W'(1);

    assign new_entry = '{
        target_addr: store_addr_i,
        write_data:  store_data_i,
        wstrb:       store_strb_i,
        valid:       1'b1,
        commit:      1'b0
    };

    // drain only retired stores in age order
    assign out_entry_o = entries[tail_q];
    assign out_valid_o = entries[tail_q].valid & entries[tail_q].commit;

    // slots picked up by this cycle's retire count
    always_comb begin
        for (int i = 0; i < SB_SIZE; i++) begin
            mark[i] = ((commit_cnt_i != 2'd0) && (PTR_W'(i) == cmt_q)) ||
                      ((commit_cnt_i == 2'd2) && (PTR_W'(i) == cmt_nxt));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q <= '0;
            cmt_q  <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            ccnt_q <= '0;
        end else if (flush_i) begin
            // keep only committed stores and drop a same-cycle push
            head_q <= cmt_q;
            tail_q <= tail_q + PTR_W'(pop);
            cnt_q  <= ccnt_q - CNT_W'(pop);
            ccnt_q <= ccnt_q - CNT_W'(pop);
        end else begin
            head_q <= head_q + PTR_W'(push);
            cmt_q  <= cmt_q + PTR_W'(commit_cnt_i);
            tail_q <= tail_q + PTR_W'(pop);
            cnt_q  <= cnt_q + CNT_W'(push) - CNT_W'(pop);
            ccnt_q <= ccnt_q + CNT_W'(commit_cnt_i) - CNT_W'(pop);
        end
    end

    // push, commit and pop never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < SB_SIZE; i++) begin
            if (!rst_n) begin
                entries[i].valid  <= 1'b0;
                entries[i].commit <= 1'b0;
            end else if (pop && (PTR_W'(i) == tail_q)) begin
                entries[i] <= '0;
            end else if (flush_i) begin
                if (!entries[i].commit) begin
                    entries[i] <= '0;
                end
            end else if (push && (PTR_W'(i) == head_q)) begin
                entries[i] <= new_entry;
            end else if (mark[i]) begin
                entries[i].commit <= 1'b1;
            end
        end
    end

    // retire never runs ahead of the buffered stores
    a_commit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        !flush_i |-> (commit_cnt_i != 2'd3) && (CNT_W'(commit_cnt_i) <= ucnt))
        else $error("store_buffer: commit count exceeds uncommitted stores");

    // an accepted store lands in a free slot
    a_push_free: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !entries[head_q].valid)
        else $error("store_buffer: push into a live slot");

endmodule

// File: design/store_fifo.sv
module store_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid_i,
    input  lsu_pkg::sb_entry_t in_entry_i,
    output logic               in_ready_o,
    output logic               out_valid_o,
    output lsu_pkg::sb_entry_t out_entry_o,
    input  logic               out_ready_i
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    lsu_pkg::sb_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             empty;
    logic             full;
    logic             bypass;
    logic             wr_en;
    logic             rd_en;

    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == CNT_W'(DEPTH));

    // empty fifo with a ready consumer acts as a wire
    assign bypass = empty & in_valid_i & out_ready_i;

    assign in_ready_o  = ~full;
    assign out_valid_o = ~empty | in_valid_i;
    assign out_entry_o = empty ? in_entry_i : mem[rd_ptr_q];

    assign wr_en = in_valid_i & in_ready_o & ~bypass;
    assign rd_en = out_ready_i & ~empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(wr_en);
            rd_ptr_q <= rd_ptr_q + PTR_W'(rd_en);
            cnt_q    <= cnt_q + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= in_entry_i;
        end
    end

    // write pointer leads the read pointer by the fill count, never past full
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        (cnt_q <= CNT_W'(DEPTH)) && (wr_ptr_q == rd_ptr_q + PTR_W'(cnt_q)))
        else $error("store_fifo: write pointer out of step with fill count");

endmodule

// File: design/store_unit_top.sv
module store_unit_top #(
    parameter int unsigned SB_SIZE    = 4,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  lsu_pkg::commit_cnt_t        commit_cnt_i,
    input  logic                        store_valid_i,
    input  logic [lsu_pkg::ADDR_W-1:0]  store_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]  store_data_i,
    input  logic [lsu_pkg::STRB_W-1:0]  store_strb_i,
    output logic                        store_ready_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [lsu_pkg::ADDR_W-1:0]  wb_adr_o,
    output logic [lsu_pkg::DATA_W-1:0]  wb_dat_o,
    output logic [lsu_pkg::STRB_W-1:0]  wb_sel_o,
    input  logic                        wb_ack_i
);

    // buffer to fifo
    logic               sb_valid;
    logic               sb_ready;
    lsu_pkg::sb_entry_t sb_entry;

    // fifo to bus master
    logic               fifo_valid;
    logic               fifo_ready;
    lsu_pkg::sb_entry_t fifo_entry;

    store_buffer #(
        .SB_SIZE (SB_SIZE)
    ) u_store_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .commit_cnt_i  (commit_cnt_i),
        .store_valid_i (store_valid_i),
        .store_addr_i  (store_addr_i),
        .store_data_i  (store_data_i),
        .store_strb_i  (store_strb_i),
        .store_ready_o (store_ready_o),
        .out_valid_o   (sb_valid),
        .out_entry_o   (sb_entry),
        .out_ready_i   (sb_ready)
    );

    store_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_store_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (sb_valid),
        .in_entry_i  (sb_entry),
        .in_ready_o  (sb_ready),
        .out_valid_o (fifo_valid),
        .out_entry_o (fifo_entry),
        .out_ready_i (fifo_ready)
    );

    wb_store_master u_wb_store_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (fifo_valid),
        .in_entry_i (fifo_entry),
        .in_ready_o (fifo_ready),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_sel_o   (wb_sel_o),
        .wb_ack_i   (wb_ack_i)
    );

endmodule

// File: design/wb_store_master.sv
module wb_store_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid_i,
    input  lsu_pkg::sb_entry_t          in_entry_i,
    output logic                        in_ready_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [lsu_pkg::ADDR_W-1:0]  wb_adr_o,
    output logic [lsu_pkg::DATA_W-1:0]  wb_dat_o,
    output logic [lsu_pkg::STRB_W-1:0]  wb_sel_o,
    input  logic                        wb_ack_i
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t                      state_q;
    logic [lsu_pkg::ADDR_W-1:0]  adr_q;
    logic [lsu_pkg::DATA_W-1:0]  dat_q;
    logic [lsu_pkg::STRB_W-1:0]  sel_q;
    logic                        accept;

    assign in_ready_o = (state_q == st_idle);
    assign accept     = in_valid_i & in_ready_o;

    // one classic write cycle per store with write enable tied high
    assign wb_cyc_o = (state_q == st_busy);
    assign wb_stb_o = (state_q == st_busy);
    assign wb_we_o  = 1'b1;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign wb_sel_o = sel_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (accept) state_q <= st_busy;
                st_busy: if (wb_ack_i) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= in_entry_i.target_addr;
            dat_q <= in_entry_i.write_data;
            sel_q <= in_entry_i.wstrb;
        end
    end

    // request held with a stable payload until acknowledged
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb_o && !wb_ack_i) |=> wb_stb_o && wb_cyc_o &&
            $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_sel_o))
        else $error("wb_store_master: request dropped or changed before ack");

    // only retired stores ever reach the bus
    a_committed_only: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> in_entry_i.valid && in_entry_i.commit)
        else $error("wb_store_master: uncommitted store offered to bus");

endmodule

// File: test/tb_store_unit.sv
module tb_store_unit;

    localparam int unsigned SB_SIZE    = 4;
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned SEED       = 42114;
    localparam int unsigned N_SINGLE   = 12;
    localparam int unsigned N_DUAL     = 10;
    localparam int unsigned N_FLUSH    = 6;
    localparam int unsigned N_STALL    = 20;
    localparam int unsigned N_RANDOM   = 300;
    // longest wait for the bus to write back every committed store
    localparam int unsigned DRAIN_LIMIT = 100;
    // stimulus cycles plus a drain allowance for each of the six tests
    localparam int unsigned TOTAL_CYCLES = 8 + 2 * N_SINGLE + 3 * N_DUAL + 4 * N_FLUSH
                                         + N_STALL + N_RANDOM + 6 * (DRAIN_LIMIT + 12);
    localparam int unsigned REC_W = lsu_pkg::ADDR_W + lsu_pkg::DATA_W + lsu_pkg::STRB_W;
    localparam logic [31:0] ADDR_BASE = 32'h1000_0000;

    logic                        clk;
    logic                        rst_n;
    logic                        flush_i;
    lsu_pkg::commit_cnt_t        commit_cnt_i;
    logic                        store_valid_i;
    logic [lsu_pkg::ADDR_W-1:0]  store_addr_i;
    logic [lsu_pkg::DATA_W-1:0]  store_data_i;
    logic [lsu_pkg::STRB_W-1:0]  store_strb_i;
    logic                        store_ready_o;
    logic                        wb_cyc_o;
    logic                        wb_stb_o;
    logic                        wb_we_o;
    logic [lsu_pkg::ADDR_W-1:0]  wb_adr_o;
    logic [lsu_pkg::DATA_W-1:0]  wb_dat_o;
    logic [lsu_pkg::STRB_W-1:0]  wb_sel_o;
    logic                        wb_ack_i;
    logic                        stall;

    // reference model of uncommitted stores and of committed stores not yet written
    logic [REC_W-1:0] unc_q [$];
    logic [REC_W-1:0] exp_q [$];
    logic [REC_W-1:0] exp_head;
    int               exp_cnt;
    int               unc_cnt;
    int               cb_cnt;
    int               f_cnt;
    bit               m_busy;
    bit               ready_exp;
    logic [31:0]      next_id;
    int               fail_cnt;
    int               tests_ok;
    int               tests_bad;

    store_unit_top #(
        .SB_SIZE    (SB_SIZE),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (.*);

    wb_mem_model u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall_i  (stall),
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb_o),
        .wb_we_i  (wb_we_o),
        .wb_ack_o (wb_ack_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        bit pop;
        bit wr;
        bit rd;
        bit acc;
        if (!rst_n) begin
            unc_q.delete();
            exp_q.delete();
            cb_cnt  = 0;
            f_cnt   = 0;
            m_busy  = 1'b0;
            next_id = '0;
        end else begin
            // moves toward the bus use the state before this edge
            acc = !m_busy && (f_cnt > 0 || cb_cnt > 0);
            rd  = !m_busy && f_cnt > 0;
            pop = cb_cnt > 0 && f_cnt < FIFO_DEPTH;
            wr  = pop && !(f_cnt == 0 && !m_busy);
            if (m_busy && wb_ack_i) begin
                void'(exp_q.pop_front());
            end
            m_busy = m_busy ? !wb_ack_i : acc;
            f_cnt  = f_cnt + int'(wr) - int'(rd);
            cb_cnt = cb_cnt - int'(pop);
            if (flush_i) begin
                unc_q.delete();
            end else begin
                for (int i = 0; i < int'(commit_cnt_i); i++) begin
                    exp_q.push_back(unc_q.pop_front());
                    cb_cnt++;
                end
                if (store_valid_i && ready_exp) begin
                    unc_q.push_back({store_addr_i, store_data_i, store_strb_i});
                    next_id = next_id + 1;
                end
            end
        end
        unc_cnt = unc_q.size();
        exp_cnt   <= exp_q.size();
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
        ready_exp <= (unc_q.size() + cb_cnt) < SB_SIZE;
    end

    task automatic report_error(input string msg);
        fail_cnt++;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    a_reset_state: assert property (@(posedge clk)
        !rst_n |=> !wb_cyc_o && !wb_stb_o && store_ready_o)
        else report_error("bus or store_ready not idle after reset");

    a_write_order: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb_o && wb_ack_i) |->
            (exp_cnt != 0) && ({wb_adr_o, wb_dat_o, wb_sel_o} == exp_head))
        else report_error("acked write differs from the oldest committed store");

    a_ready_level: assert property (@(posedge clk) disable iff (!rst_n)
        store_ready_o == ready_exp)
        else report_error("store_ready disagrees with buffer occupancy");

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb_o && !wb_ack_i) |=> wb_cyc_o && wb_stb_o &&
            $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_sel_o))
        else report_error("bus request dropped or changed before ack");

    a_bus_shape: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o |-> wb_cyc_o && wb_we_o)
        else report_error("stb without cyc or write enable");

    // one cycle of execute and retire inputs
    task automatic drive(input bit valid, input int commits, input bit do_flush);
        int n;
        @(negedge clk);
        n = (commits > unc_cnt) ? unc_cnt : commits;
        store_valid_i = valid && !do_flush;
        store_addr_i  = ADDR_BASE + (next_id << 2);
        store_data_i  = (next_id * 32'h9E37_79B1) ^ 32'h0BAD_F00D;
        store_strb_i  = 4'(next_id % 15 + 1);
        commit_cnt_i  = do_flush ? 2'd0 : lsu_pkg::commit_cnt_t'(n);
        flush_i       = do_flush;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int waited;
        stall = 1'b0;
        // retire the rest so every accepted store has to reach memory
        while (unc_cnt != 0) begin
            drive(1'b0, 2, 1'b0);
        end
        waited = 0;
        while (exp_cnt != 0 && waited < DRAIN_LIMIT) begin
            drive(1'b0, 0, 1'b0);
            waited++;
        end
        repeat (10) drive(1'b0, 0, 1'b0);
        assert (exp_cnt == 0 && !wb_cyc_o)
            else report_error("committed stores not written or bus still active after drain");
        if (fail_cnt == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, fail_cnt - errs_before);
        end
    endtask

    initial begin
        #(TOTAL_CYCLES * 4 * 20);
        $display("simulation timed out before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int start;
        void'($urandom(SEED));
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        commit_cnt_i  = '0;
        store_valid_i = 1'b0;
        store_addr_i  = '0;
        store_data_i  = '0;
        store_strb_i  = '0;
        stall         = 1'b0;
        fail_cnt      = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        start = fail_cnt;
        drive(1'b0, 0, 1'b0);
        finish_test("reset", start);

        start = fail_cnt;
        repeat (N_SINGLE) begin
            drive(1'b1, 0, 1'b0);
            drive(1'b0, 1, 1'b0);
        end
        finish_test("single commits", start);

        // two stores retired in the same cycle
        start = fail_cnt;
        repeat (N_DUAL) begin
            drive(1'b1, 0, 1'b0);
            drive(1'b1, 0, 1'b0);
            drive(1'b0, 2, 1'b0);
        end
        finish_test("dual commits", start);

        // oldest store retires while the two younger ones get flushed
        start = fail_cnt;
        repeat (N_FLUSH) begin
            drive(1'b1, 0, 1'b0);
            drive(1'b1, 1, 1'b0);
            drive(1'b1, 0, 1'b0);
            drive(1'b0, 0, 1'b1);
        end
        finish_test("flush recovery", start);

        // bus held off until master, FIFO and buffer are all full
        start = fail_cnt;
        stall = 1'b1;
        repeat (N_STALL) drive(1'b1, 2, 1'b0);
        finish_test("back-pressure", start);

        start = fail_cnt;
        repeat (N_RANDOM) begin
            drive(1'($urandom_range(1, 0)), int'($urandom_range(2, 0)),
                  $urandom_range(15, 0) == 0);
            stall = ($urandom_range(7, 0) == 0);
        end
        finish_test("random traffic", start);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_ok, tests_bad, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: test/wb_mem_model.sv
module wb_mem_model (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    output logic wb_ack_o
);

    // wait states left in the current bus cycle
    int unsigned wait_q;
    logic        armed_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
            armed_q  <= 1'b0;
            wait_q   <= 0;
        end else if (wb_ack_o) begin
            // ack lasts one cycle before the next request is looked for
            wb_ack_o <= 1'b0;
            armed_q  <= 1'b0;
        end else if (wb_cyc_i && wb_stb_i && wb_we_i) begin
            if (!armed_q) begin
                armed_q <= 1'b1;
                wait_q  <= $urandom_range(3, 0);
            end else if (wait_q != 0) begin
                wait_q <= wait_q - 1;
            end else if (!stall_i) begin
                wb_ack_o <= 1'b1;
            end
        end
    end

endmodule
